// File: tlbPkg.sv
package tlbPkg;

    localparam int vppnW = 19;
    localparam int asidW = 10;
    localparam int ppnW  = 20;

    // lowest vppn bit still compared for a 2 MiB entry
    localparam int hugeLsb = 9;

    // page size codes as held in the entry
    typedef enum logic [5:0] {
        ps4k = 6'd12,
        ps2m = 6'd21
    } pageSize_t;

    // one half of a page pair
    typedef struct packed {
        logic [ppnW-1:0] ppn;
        logic [1:0]      plv;
        logic [1:0]      mat;
        logic            d;
        logic            v;
    } pageAttr_t;

    typedef struct packed {
        logic [vppnW-1:0] vppn;
        pageSize_t        ps;
        logic [asidW-1:0] asid;
        logic             g;
        logic             e;
        pageAttr_t        page0;
        pageAttr_t        page1;
    } tlbEntry_t;

    typedef struct packed {
        logic             valid;
        logic [vppnW-1:0] vppn;
        logic             oddPage;
        logic [asidW-1:0] asid;
    } lookupReq_t;

    typedef struct packed {
        logic      valid;
        logic      found;
        pageSize_t ps;
        pageAttr_t page;
    } lookupResp_t;

    typedef enum logic [2:0] {
        opWrite,
        opRead,
        opInvAll,
        opInvGlobal,
        opInvNonGlobal,
        opInvAsid,
        opInvAsidVa,
        opInvGlobalOrAsidVa
    } maintOp_t;

    typedef struct packed {
        maintOp_t         op;
        logic [asidW-1:0] asid;
        logic [vppnW-1:0] vppn;
        tlbEntry_t        entry;
    } maintReq_t;

    // huge pages ignore the low vppn bits
    function automatic logic vppnHit(tlbEntry_t ent, logic [vppnW-1:0] vppn);
        if (ent.ps == ps4k) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[vppnW-1:hugeLsb] == vppn[vppnW-1:hugeLsb];
    endfunction

endpackage

// File: tlbEntryArray.sv
module tlbEntryArray
    import tlbPkg::*;
#(
    parameter int tlbNum = 64
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      wrEn,
    input  logic [$clog2(tlbNum)-1:0] wrIndex,
    input  tlbEntry_t                 wrEntry,
    input  logic                      invEn,
    input  maintOp_t                  invOp,
    input  logic [asidW-1:0]          invAsid,
    input  logic [vppnW-1:0]          invVppn,
    input  logic [$clog2(tlbNum)-1:0] rdIndex,
    output tlbEntry_t                 rdEntry,
    output tlbEntry_t [tlbNum-1:0]    entries
);

    // payload storage apart from the E bits
    tlbEntry_t         store [tlbNum];
    logic [tlbNum-1:0] eBits;
    logic [tlbNum-1:0] invHit;

    always_ff @(posedge Clk) begin
        if (wrEn) begin
            store[wrIndex] <= wrEntry;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            eBits <= '0;
        end else if (wrEn) begin
            eBits[wrIndex] <= wrEntry.e;
        end else if (invEn) begin
            eBits <= eBits & ~invHit;
        end
    end

    // which entries the current invalidate op selects
    always_comb begin
        logic asidEq;
        logic vaEq;
        invHit = '0;
        for (int i = 0; i < tlbNum; i++) begin
            asidEq = store[i].asid == invAsid;
            vaEq   = vppnHit(store[i], invVppn);
            case (invOp)
                opInvAll:            invHit[i] = 1'b1;
                opInvGlobal:         invHit[i] = store[i].g;
                opInvNonGlobal:      invHit[i] = !store[i].g;
                opInvAsid:           invHit[i] = !store[i].g && asidEq;
                opInvAsidVa:         invHit[i] = !store[i].g && asidEq && vaEq;
                opInvGlobalOrAsidVa: invHit[i] = (store[i].g || asidEq) && vaEq;
                default:             invHit[i] = 1'b0;
            endcase
        end
    end

    // flat view with the live E bit merged in
    always_comb begin
        for (int i = 0; i < tlbNum; i++) begin
            entries[i]   = store[i];
            entries[i].e = eBits[i];
        end
    end

    assign rdEntry = entries[rdIndex];

endmodule

// File: tlbMatchPort.sv
module tlbMatchPort
    import tlbPkg::*;
#(
    parameter int tlbNum = 64
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  lookupReq_t                req,
    input  tlbEntry_t [tlbNum-1:0]    entries,
    output lookupResp_t               resp,
    output logic [$clog2(tlbNum)-1:0] respIndex
);

    localparam int idxW = $clog2(tlbNum);

    logic [tlbNum-1:0] hit;
    logic [tlbNum-1:0] sel;
    logic [idxW-1:0]   hitIdx;
    logic              anyHit;
    lookupResp_t       respNext;
    logic [idxW-1:0]   indexNext;

    for (genvar i = 0; i < tlbNum; i++) begin : gCmp
        logic asidOk;

        assign asidOk = entries[i].g || (entries[i].asid == req.asid);
        assign hit[i] = entries[i].e && asidOk && vppnHit(entries[i], req.vppn);
        // odd page from the request bit for 4k and vppn bit 8 for 2m
        assign sel[i] = (entries[i].ps == ps4k) ? req.oddPage : req.vppn[hugeLsb-1];
    end

    // scan downward so the lowest index wins
    always_comb begin
        hitIdx = '0;
        anyHit = 1'b0;
        for (int i = tlbNum - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hitIdx = idxW'(i);
                anyHit = 1'b1;
            end
        end
    end

    always_comb begin
        respNext       = '0;
        indexNext      = '0;
        respNext.valid = req.valid;
        if (req.valid && anyHit) begin
            respNext.found = 1'b1;
            respNext.ps    = entries[hitIdx].ps;
            respNext.page  = sel[hitIdx] ? entries[hitIdx].page1 : entries[hitIdx].page0;
            indexNext      = hitIdx;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            resp      <= '0;
            respIndex <= '0;
        end else begin
            resp      <= respNext;
            respIndex <= indexNext;
        end
    end

endmodule

// File: tlbMaintCtrl.sv
module tlbMaintCtrl
    import tlbPkg::*;
#(
    parameter int tlbNum = 64
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      reqValid,
    input  maintReq_t                 cmd,
    input  logic [$clog2(tlbNum)-1:0] index,
    output logic                      ack,
    output tlbEntry_t                 rdata,
    output logic                      wrEn,
    output logic [$clog2(tlbNum)-1:0] wrIndex,
    output tlbEntry_t                 wrEntry,
    output logic                      invEn,
    output maintOp_t                  invOp,
    output logic [asidW-1:0]          invAsid,
    output logic [vppnW-1:0]          invVppn,
    output logic [$clog2(tlbNum)-1:0] rdIndex,
    input  tlbEntry_t                 rdEntry
);

    localparam int idxW = $clog2(tlbNum);

    typedef enum logic [1:0] {
        stIdle,
        stExec,
        stHold,
        stRelease
    } state_t;

    state_t          state;
    maintReq_t       cmdReg;
    logic [idxW-1:0] indexReg;
    logic            isInv;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            ack   <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (reqValid) begin
                        state <= stExec;
                    end
                end
                stExec: state <= stHold;
                stHold: begin
                    // first hold cycle raises ack, then wait for req to drop
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!reqValid) begin
                        state <= stRelease;
                    end
                end
                stRelease: begin
                    ack   <= 1'b0;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // command captured when the request is accepted
    always_ff @(posedge Clk) begin
        if (state == stIdle && reqValid) begin
            cmdReg   <= cmd;
            indexReg <= index;
        end
        if (state == stExec && cmdReg.op == opRead) begin
            rdata <= rdEntry;
        end
    end

    assign isInv = !(cmdReg.op inside {opWrite, opRead});

    assign wrEn    = (state == stExec) && (cmdReg.op == opWrite);
    assign invEn   = (state == stExec) && isInv;
    assign wrIndex = indexReg;
    assign rdIndex = indexReg;
    assign wrEntry = cmdReg.entry;
    assign invOp   = cmdReg.op;
    assign invAsid = cmdReg.asid;
    assign invVppn = cmdReg.vppn;

endmodule

// File: tlb.sv
module tlb
    import tlbPkg::*;
#(
    parameter int tlbNum = 64
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  lookupReq_t                fetchReq,
    input  lookupReq_t                dataReq,
    output lookupResp_t               fetchResp,
    output lookupResp_t               dataResp,
    output logic [$clog2(tlbNum)-1:0] fetchIndex,
    output logic [$clog2(tlbNum)-1:0] dataIndex,
    input  logic                      maintReqValid,
    input  maintReq_t                 maintCmd,
    input  logic [$clog2(tlbNum)-1:0] maintIndex,
    output logic                      maintAck,
    output tlbEntry_t                 maintRdata
);

    localparam int idxW = $clog2(tlbNum);

    tlbEntry_t [tlbNum-1:0] entries;
    tlbEntry_t              rdEntry;
    tlbEntry_t              wrEntry;
    logic                   wrEn;
    logic                   invEn;
    logic [idxW-1:0]        wrIndex;
    logic [idxW-1:0]        rdIndex;
    maintOp_t               invOp;
    logic [asidW-1:0]       invAsid;
    logic [vppnW-1:0]       invVppn;

    tlbEntryArray #(.tlbNum(tlbNum)) entryArray (
        .Clk     (Clk),
        .arstN   (arstN),
        .wrEn    (wrEn),
        .wrIndex (wrIndex),
        .wrEntry (wrEntry),
        .invEn   (invEn),
        .invOp   (invOp),
        .invAsid (invAsid),
        .invVppn (invVppn),
        .rdIndex (rdIndex),
        .rdEntry (rdEntry),
        .entries (entries)
    );

    // both ports see the whole array at once
    tlbMatchPort #(.tlbNum(tlbNum)) fetchPort (
        .Clk       (Clk),
        .arstN     (arstN),
        .req       (fetchReq),
        .entries   (entries),
        .resp      (fetchResp),
        .respIndex (fetchIndex)
    );

    tlbMatchPort #(.tlbNum(tlbNum)) dataPort (
        .Clk       (Clk),
        .arstN     (arstN),
        .req       (dataReq),
        .entries   (entries),
        .resp      (dataResp),
        .respIndex (dataIndex)
    );

    tlbMaintCtrl #(.tlbNum(tlbNum)) maintCtrl (
        .Clk      (Clk),
        .arstN    (arstN),
        .reqValid (maintReqValid),
        .cmd      (maintCmd),
        .index    (maintIndex),
        .ack      (maintAck),
        .rdata    (maintRdata),
        .wrEn     (wrEn),
        .wrIndex  (wrIndex),
        .wrEntry  (wrEntry),
        .invEn    (invEn),
        .invOp    (invOp),
        .invAsid  (invAsid),
        .invVppn  (invVppn),
        .rdIndex  (rdIndex),
        .rdEntry  (rdEntry)
    );

endmodule

// File: tbTlbCheck.svh
`ifndef TB_TLB_CHECK_SVH
`define TB_TLB_CHECK_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic checkEntry(string name, tlbEntry_t exp, tlbEntry_t act);
    if (act !== exp) begin
        $display("** Error %s: expected %h actual %h", name, exp, act);
        failRun();
    end
endtask

// response and its index are judged together
task automatic checkResp(string name, lookupResp_t expResp, logic [idxW-1:0] expIdx,
                         lookupResp_t actResp, logic [idxW-1:0] actIdx);
    if (actResp !== expResp || actIdx !== expIdx) begin
        $display("** Error %s: expected %h idx %0d actual %h idx %0d",
                 name, expResp, expIdx, actResp, actIdx);
        failRun();
    end
endtask

task automatic checkFlag(string name, logic exp, logic act);
    if (act !== exp) begin
        $display("** Error %s: expected %b actual %b", name, exp, act);
        failRun();
    end
endtask

`endif

// File: tbTlb.sv
module tbTlb
    import tlbPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tlbNum      = 64;
    localparam int idxW        = $clog2(tlbNum);
    localparam int resetCycles = 8;
    localparam int ackWait     = 40;

    logic            Clk = 1'b0;
    logic            arstN;
    lookupReq_t      fetchReq;
    lookupReq_t      dataReq;
    lookupResp_t     fetchResp;
    lookupResp_t     dataResp;
    logic [idxW-1:0] fetchIndex;
    logic [idxW-1:0] dataIndex;
    logic            maintReqValid;
    maintReq_t       maintCmd;
    logic [idxW-1:0] maintIndex;
    logic            maintAck;
    tlbEntry_t       maintRdata;

    logic [31:0] lfsr       = 32'h2b67_0af8;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          fd;
    string       testName;

    tlb #(.tlbNum(tlbNum)) UUT (
        .Clk           (Clk),
        .arstN         (arstN),
        .fetchReq      (fetchReq),
        .dataReq       (dataReq),
        .fetchResp     (fetchResp),
        .dataResp      (dataResp),
        .fetchIndex    (fetchIndex),
        .dataIndex     (dataIndex),
        .maintReqValid (maintReqValid),
        .maintCmd      (maintCmd),
        .maintIndex    (maintIndex),
        .maintAck      (maintAck),
        .maintRdata    (maintRdata)
    );

    always #2 Clk = ~Clk;

    task automatic failRun();
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tbTlbCheck.svh"

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            failRun();
        end
    end

    // two bits per draw give 0 to 3 idle cycles
    task automatic drawDelay(output int n);
        lfsr = lfsrNext(lfsr);
        n    = lfsr[0];
        lfsr = lfsrNext(lfsr);
        n    = n * 2 + lfsr[0];
    endtask

    task automatic handshake(input maintReq_t cmd, input logic [idxW-1:0] idx,
                             output tlbEntry_t rdata);
        int d;
        int waited;
        drawDelay(d);
        repeat (d) @(posedge Clk);
        @(negedge Clk);
        checkFlag({testName, " ack idle"}, 1'b0, maintAck);
        @(posedge Clk);
        maintReqValid <= 1'b1;
        maintCmd      <= cmd;
        maintIndex    <= idx;
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
            if (waited > ackWait) begin
                $display("%s: maintenance ack never rose", testName);
                failRun();
            end
        end while (!maintAck);
        // req seen one edge after the drive, ack raised two edges after that
        checkFlag({testName, " ack latency"}, 1'b1, waited == 4);
        rdata = maintRdata;
        drawDelay(d);
        repeat (d) begin
            @(negedge Clk);
            checkFlag({testName, " ack held"}, 1'b1, maintAck);
        end
        @(posedge Clk);
        maintReqValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
            if (waited > ackWait) begin
                $display("%s: maintenance ack never fell", testName);
                failRun();
            end
        end while (maintAck);
    endtask

    // an unused port gets valid low and must answer valid low
    task automatic lookup(input logic useF, input lookupReq_t fReq, input lookupResp_t fExp,
                          input logic [idxW-1:0] fIdx, input logic useD,
                          input lookupReq_t dReq, input lookupResp_t dExp,
                          input logic [idxW-1:0] dIdx);
        @(posedge Clk);
        fetchReq <= useF ? fReq : '0;
        dataReq  <= useD ? dReq : '0;
        @(posedge Clk);
        fetchReq <= '0;
        dataReq  <= '0;
        @(negedge Clk);
        if (useF) checkResp({testName, " fetch"}, fExp, fIdx, fetchResp, fetchIndex);
        else checkFlag({testName, " fetch valid"}, 1'b0, fetchResp.valid);
        if (useD) checkResp({testName, " data"}, dExp, dIdx, dataResp, dataIndex);
        else checkFlag({testName, " data valid"}, 1'b0, dataResp.valid);
    endtask

    task automatic readEntry(output logic [idxW-1:0] idx, output tlbEntry_t ent);
        logic [31:0] v [16];
        if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15]) != 16) begin
            $display("%s: malformed entry fields", testName);
            failRun();
        end
        idx  = v[0][idxW-1:0];
        ent  = '0;
        ent.vppn  = v[1][vppnW-1:0];
        ent.ps    = pageSize_t'(v[2][5:0]);
        ent.asid  = v[3][asidW-1:0];
        ent.g     = v[4][0];
        ent.e     = v[5][0];
        ent.page0 = {v[6][ppnW-1:0], v[7][1:0], v[8][1:0], v[9][0], v[10][0]};
        ent.page1 = {v[11][ppnW-1:0], v[12][1:0], v[13][1:0], v[14][0], v[15][0]};
    endtask

    initial begin
        string           kind;
        string           lineBuf;
        int              nLines;
        int              cmdNo;
        logic [31:0]     v [12];
        logic            pending;
        lookupReq_t      req;
        lookupReq_t      heldReq;
        lookupResp_t     exp;
        lookupResp_t     heldExp;
        logic [idxW-1:0] heldIdx;
        logic [idxW-1:0] idx;
        tlbEntry_t       ent;
        tlbEntry_t       got;
        maintReq_t       cmd;

        arstN         = 1'b0;
        fetchReq      = '0;
        dataReq       = '0;
        maintReqValid = 1'b0;
        maintCmd      = '0;
        maintIndex    = '0;
        pending       = 1'b0;
        nLines        = 0;
        cmdNo         = 0;

        fd = $fopen("tlbStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file tlbStim.txt");
            failRun();
        end
        while (!$feof(fd)) begin
            if ($fgets(lineBuf, fd) > 0) nLines++;
        end
        $fclose(fd);
        cycleLimit = nLines * 20 + resetCycles;

        repeat (resetCycles) @(posedge Clk);
        arstN <= 1'b1;

        fd = $fopen("tlbStim.txt", "r");
        while ($fscanf(fd, "%s", kind) == 1) begin
            cmdNo++;
            testName = $sformatf("cmd %0d %s", cmdNo, kind);
            cmd = '0;
            case (kind)
                "#": void'($fgets(lineBuf, fd));
                "W", "R": begin
                    readEntry(idx, ent);
                    cmd.op    = (kind == "W") ? opWrite : opRead;
                    cmd.entry = ent;
                    handshake(cmd, idx, got);
                    if (kind == "R") checkEntry(testName, ent, got);
                end
                "I": begin
                    void'($fscanf(fd, "%h %h %h", v[0], v[1], v[2]));
                    cmd.op   = maintOp_t'(v[0][2:0]);
                    cmd.asid = v[1][asidW-1:0];
                    cmd.vppn = v[2][vppnW-1:0];
                    handshake(cmd, '0, got);
                end
                "N": lookup(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
                "L": begin
                    if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                                v[9], v[10], v[11]) != 12) begin
                        $display("%s: malformed lookup fields", testName);
                        failRun();
                    end
                    req     = {1'b1, v[1][vppnW-1:0], v[2][0], v[3][asidW-1:0]};
                    exp     = '0;
                    exp.valid = 1'b1;
                    exp.found = v[4][0];
                    exp.ps    = pageSize_t'(v[6][5:0]);
                    exp.page  = {v[7][ppnW-1:0], v[8][1:0], v[9][1:0], v[10][0], v[11][0]};
                    idx     = v[5][idxW-1:0];
                    // port 2 holds a fetch lookup for the next data line
                    if (v[0] == 2) begin
                        pending = 1'b1;
                        heldReq = req;
                        heldExp = exp;
                        heldIdx = idx;
                    end else if (v[0] == 1) begin
                        lookup(pending, heldReq, heldExp, heldIdx, 1'b1, req, exp, idx);
                        pending = 1'b0;
                    end else begin
                        lookup(1'b1, req, exp, idx, 1'b0, '0, '0, '0);
                    end
                end
                default: begin
                    $display("unknown stimulus command %s", kind);
                    failRun();
                end
            endcase
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tlbStim.txt
# W/R idx vppn ps asid g e ppn0 plv0 mat0 d0 v0 ppn1 plv1 mat1 d1 v1, R expects these
# I op asid vppn; L port(0 fetch 1 data 2 fetch paired) vppn odd asid found idx ps ppn plv mat d v
# N both ports idle, all values hex
N
L 0 00123 0 001 0 00 00 00000 0 0 0 0
L 1 04233 1 3ff 0 00 00 00000 0 0 0 0
W 05 00123 0c 001 0 1 0a000 0 1 1 1 0a001 3 1 0 1
W 09 04200 15 002 1 1 0b000 0 1 1 1 0b200 0 0 1 1
R 05 00123 0c 001 0 1 0a000 0 1 1 1 0a001 3 1 0 1
R 09 04200 15 002 1 1 0b000 0 1 1 1 0b200 0 0 1 1
L 0 00123 0 001 1 05 0c 0a000 0 1 1 1
L 1 00123 1 001 1 05 0c 0a001 3 1 0 1
L 0 00123 0 003 0 00 00 00000 0 0 0 0
L 1 04233 1 3ff 1 09 15 0b000 0 1 1 1
L 0 04300 0 000 1 09 15 0b200 0 0 1 1
L 1 04400 0 002 0 00 00 00000 0 0 0 0
W 0c 00123 0c 001 1 1 0c000 1 2 1 1 0c001 1 2 0 1
L 2 00123 0 001 1 05 0c 0a000 0 1 1 1
L 1 00123 1 007 1 0c 0c 0c001 1 2 0 1
L 2 00123 1 001 1 05 0c 0a001 3 1 0 1
L 1 04233 0 001 1 09 15 0b000 0 1 1 1
W 14 00500 0c 001 0 1 0d000 0 1 1 1 0d001 0 1 1 1
W 15 00500 0c 002 0 1 0e000 0 1 1 1 0e001 0 1 1 1
W 16 00600 0c 001 1 1 0f000 0 1 1 1 0f001 0 1 1 1
I 6 001 00500
R 14 00500 0c 001 0 0 0d000 0 1 1 1 0d001 0 1 1 1
L 1 00500 0 002 1 15 0c 0e000 0 1 1 1
I 7 002 00600
R 16 00600 0c 001 1 0 0f000 0 1 1 1 0f001 0 1 1 1
L 0 00123 0 007 1 0c 0c 0c000 1 2 1 1
I 5 002 00000
R 15 00500 0c 002 0 0 0e000 0 1 1 1 0e001 0 1 1 1
L 0 00123 0 001 1 05 0c 0a000 0 1 1 1
W 14 00500 0c 001 0 1 0d000 0 1 1 1 0d001 0 1 1 1
W 15 00500 0c 002 0 1 0e000 0 1 1 1 0e001 0 1 1 1
W 16 00600 0c 001 1 1 0f000 0 1 1 1 0f001 0 1 1 1
I 4 000 00000
R 14 00500 0c 001 0 0 0d000 0 1 1 1 0d001 0 1 1 1
R 16 00600 0c 001 1 1 0f000 0 1 1 1 0f001 0 1 1 1
L 1 00123 1 001 1 0c 0c 0c001 1 2 0 1
I 3 000 00000
R 16 00600 0c 001 1 0 0f000 0 1 1 1 0f001 0 1 1 1
L 0 00123 0 001 0 00 00 00000 0 0 0 0
L 1 04233 0 002 0 00 00 00000 0 0 0 0
W 14 00500 0c 001 0 1 0d000 0 1 1 1 0d001 0 1 1 1
I 2 000 00000
R 14 00500 0c 001 0 0 0d000 0 1 1 1 0d001 0 1 1 1
L 0 00500 0 001 0 00 00 00000 0 0 0 0

// File: vlog.f
+incdir+.
tlbPkg.sv
tlbEntryArray.sv
tlbMatchPort.sv
tlbMaintCtrl.sv
tlb.sv
tbTlb.sv
